//--- Bender.yml
package:
  name: rx_meta

sources:
  - logic/rx_meta_pkg.sv
  - logic/sync_fifo.sv
  - logic/head_update_monitor.sv
  - logic/meta_dispatcher.sv
  - logic/pkt_queue_manager.sv
  - logic/ordered_mux.sv
  - logic/rx_meta_top.sv
  - target: test
    files:
      - test/rx_meta_tb.sv

//--- logic/head_update_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module head_update_monitor (
    input  logic                     pcie_clk,
    input  logic                     pcie_reset_n,
    input  rx_meta_pkg::mmio_write_t mmio_write,
    output logic                     head_upd_valid,
    output rx_meta_pkg::flow_idx_t   head_upd_flow,
    input  logic                     head_upd_ready,
    output rx_meta_pkg::counter_t    ignored_head_cnt
);

import rx_meta_pkg::*;

logic [TABLE_IDX_WIDTH-1:0]    queue_field;
logic                          head_write;
logic                          almost_full;
logic [HEAD_UPD_OCC_WIDTH-1:0] occupancy;
logic                          push_valid;
flow_idx_t                     push_flow;
logic                          push_ready;

assign queue_field = mmio_write.address[QUEUE_FIELD_LSB +: TABLE_IDX_WIDTH];

// Only a full-width write to the head register of a valid flow counts.
assign head_write = mmio_write.write && (queue_field < MAX_NB_FLOWS) &&
    (mmio_write.byteenable[HEAD_REG_INDEX*REG_SIZE +: REG_SIZE] == {REG_SIZE{1'b1}});

assign almost_full =
    occupancy > HEAD_UPD_OCC_WIDTH'(HEAD_UPD_QUEUE_LEN - HEAD_UPD_SLACK);

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        push_valid       <= 1'b0;
        ignored_head_cnt <= '0;
    end else begin
        push_valid <= head_write && !almost_full;
        if (head_write && almost_full) begin
            ignored_head_cnt <= ignored_head_cnt + 1'b1;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (head_write) begin
        push_flow <= queue_field[FLOW_IDX_WIDTH-1:0];
    end
end

sync_fifo #(
    .WIDTH (FLOW_IDX_WIDTH),
    .DEPTH (HEAD_UPD_QUEUE_LEN)
) head_upd_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (push_flow),
    .in_valid     (push_valid),
    .in_ready     (push_ready),
    .out_data     (head_upd_flow),
    .out_valid    (head_upd_valid),
    .out_ready    (head_upd_ready),
    .occupancy    (occupancy)
);

// The slack must cover the write that is still in the register.
head_push_accepted: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    head_write && !almost_full |=> push_ready
);

endmodule

`default_nettype wire

//--- logic/meta_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module meta_dispatcher (
    input  logic                                          pcie_clk,
    input  logic                                          pcie_reset_n,
    input  logic                                          head_upd_valid,
    input  rx_meta_pkg::flow_idx_t                        head_upd_flow,
    output logic                                          head_upd_ready,
    input  logic                                          in_meta_valid,
    input  rx_meta_pkg::pkt_meta_t                        in_meta,
    output logic                                          in_meta_ready,
    output logic [rx_meta_pkg::NB_PKT_QUEUE_MANAGERS-1:0] qm_in_valid,
    output rx_meta_pkg::rx_meta_t                         qm_in_data,
    input  logic [rx_meta_pkg::NB_PKT_QUEUE_MANAGERS-1:0] qm_in_ready,
    output logic                                          order_valid,
    output rx_meta_pkg::pkt_qm_id_t                       order_id,
    input  logic                                          order_ready,
    output rx_meta_pkg::counter_t                         head_upd_cnt
);

import rx_meta_pkg::*;

logic                          merge;
logic                          head_acc;
logic                          meta_acc;
rx_meta_t                      next_rec;
logic [IN_QUEUE_OCC_WIDTH-1:0] iq_occupancy;
logic                          iq_almost_full;
logic                          iq_in_valid;
rx_meta_t                      iq_in_data;
logic                          iq_out_valid;
rx_meta_t                      iq_out_data;
logic                          iq_out_ready;
logic                          steer_valid;
rx_meta_t                      steer_data;
pkt_qm_id_t                    qm_id;
logic                          release_rec;

assign iq_almost_full = iq_occupancy > IN_QUEUE_OCC_WIDTH'(IN_QUEUE_THRESHOLD);

// Head updates win. A packet to the same flow rides along with the update.
always_comb begin
    head_upd_ready = 1'b0;
    in_meta_ready  = 1'b0;
    merge          = 1'b0;
    if (!iq_almost_full) begin
        head_upd_ready = 1'b1;
        if (head_upd_valid) begin
            merge         = in_meta_valid && (in_meta.flow_idx == head_upd_flow);
            in_meta_ready = merge;
        end else begin
            in_meta_ready = 1'b1;
        end
    end
end

assign head_acc = head_upd_valid && head_upd_ready;
assign meta_acc = in_meta_valid && in_meta_ready;

always_comb begin
    next_rec = '0;
    if (meta_acc) begin
        next_rec.flow_idx  = in_meta.flow_idx;
        next_rec.size      = in_meta.size;
        next_rec.needs_dsc = merge;
    end else begin
        next_rec.flow_idx        = head_upd_flow;
        next_rec.descriptor_only = 1'b1;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        iq_in_valid  <= 1'b0;
        head_upd_cnt <= '0;
    end else begin
        iq_in_valid <= head_acc || meta_acc;
        if (head_acc) begin
            head_upd_cnt <= head_upd_cnt + 1'b1;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (head_acc || meta_acc) begin
        iq_in_data <= next_rec;
    end
end

sync_fifo #(
    .WIDTH ($bits(rx_meta_t)),
    .DEPTH (IN_QUEUE_LEN)
) in_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (iq_in_data),
    .in_valid     (iq_in_valid),
    .in_ready     (),
    .out_data     (iq_out_data),
    .out_valid    (iq_out_valid),
    .out_ready    (iq_out_ready),
    .occupancy    (iq_occupancy)
);

// Manager and order queue take the record in the same cycle.
assign qm_id       = steer_data.flow_idx[PKT_QM_ID_WIDTH-1:0];
assign release_rec = steer_valid && order_ready && qm_in_ready[qm_id];

always_comb begin
    qm_in_valid        = '0;
    qm_in_valid[qm_id] = steer_valid && order_ready;
end

assign qm_in_data   = steer_data;
assign order_valid  = steer_valid && qm_in_ready[qm_id];
assign order_id     = qm_id;
assign iq_out_ready = !steer_valid || release_rec;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        steer_valid <= 1'b0;
    end else if (iq_out_valid && iq_out_ready) begin
        steer_valid <= 1'b1;
    end else if (release_rec) begin
        steer_valid <= 1'b0;
    end
end

always_ff @(posedge pcie_clk) begin
    if (iq_out_valid && iq_out_ready) begin
        steer_data <= iq_out_data;
    end
end

endmodule

`default_nettype wire

//--- logic/ordered_mux.sv
`timescale 1ns/1ps
`default_nettype none

module ordered_mux (
    input  logic                                                     pcie_clk,
    input  logic                                                     pcie_reset_n,
    input  logic                                                     order_valid,
    input  rx_meta_pkg::pkt_qm_id_t                                  order_id,
    output logic                                                     order_ready,
    input  logic [rx_meta_pkg::NB_PKT_QUEUE_MANAGERS-1:0]            qm_out_valid,
    input  rx_meta_pkg::dsc_meta_t [rx_meta_pkg::NB_PKT_QUEUE_MANAGERS-1:0] qm_out_data,
    output logic [rx_meta_pkg::NB_PKT_QUEUE_MANAGERS-1:0]            qm_out_ready,
    output logic                                                     out_valid,
    output rx_meta_pkg::dsc_meta_t                                   out_meta,
    input  logic                                                     out_ready
);

import rx_meta_pkg::*;

pkt_qm_id_t sel;
logic       sel_valid;
logic       sel_pop;

sync_fifo #(
    .WIDTH (PKT_QM_ID_WIDTH),
    .DEPTH (ORDER_QUEUE_LEN)
) order_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (order_id),
    .in_valid     (order_valid),
    .in_ready     (order_ready),
    .out_data     (sel),
    .out_valid    (sel_valid),
    .out_ready    (sel_pop),
    .occupancy    ()
);

// Only the manager at the head of the order queue may hand over a record.
assign out_valid = sel_valid && qm_out_valid[sel];
assign out_meta  = qm_out_data[sel];
assign sel_pop   = out_valid && out_ready;

always_comb begin
    qm_out_ready      = '0;
    qm_out_ready[sel] = sel_valid && out_ready;
end

// A manager output always has its order entry queued alongside.
no_orphan_record: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    (|qm_out_valid) |-> sel_valid
);

endmodule

`default_nettype wire

//--- logic/pkt_queue_manager.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_queue_manager (
    input  logic                    pcie_clk,
    input  logic                    pcie_reset_n,
    input  rx_meta_pkg::rx_config_t cfg,
    input  logic                    in_valid,
    input  rx_meta_pkg::rx_meta_t   in_data,
    output logic                    in_ready,
    output logic                    out_valid,
    output rx_meta_pkg::dsc_meta_t  out_data,
    input  logic                    out_ready
);

import rx_meta_pkg::*;

rb_ptr_t                     tails [NB_LOCAL_FLOWS];
logic [LOCAL_FLOW_WIDTH-1:0] local_flow;
rb_ptr_t                     cur_tail;
logic [RB_WIDTH:0]           tail_sum;
rb_ptr_t                     next_tail;
logic                        in_acc;

// Low flow bits picked this manager, the upper ones pick the tail.
assign local_flow = in_data.flow_idx[PKT_QM_ID_WIDTH +: LOCAL_FLOW_WIDTH];
assign cur_tail   = tails[local_flow];
assign tail_sum   = {1'b0, cur_tail} + (RB_WIDTH + 1)'(in_data.size);

// Size is below the ring size, so one subtraction wraps.
assign next_tail = (tail_sum >= {1'b0, cfg.rb_size}) ?
    RB_WIDTH'(tail_sum - {1'b0, cfg.rb_size}) : tail_sum[RB_WIDTH-1:0];

assign in_ready = !out_valid || out_ready;
assign in_acc   = in_valid && in_ready;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        out_valid <= 1'b0;
        for (int i = 0; i < NB_LOCAL_FLOWS; i++) begin
            tails[i] <= '0;
        end
    end else if (in_acc) begin
        out_valid         <= 1'b1;
        tails[local_flow] <= next_tail;
    end else if (out_ready) begin
        out_valid <= 1'b0;
    end
end

always_ff @(posedge pcie_clk) begin
    if (in_acc) begin
        out_data.meta           <= in_data;
        out_data.meta.needs_dsc <=
            in_data.needs_dsc || in_data.descriptor_only || cfg.desc_per_pkt;
        out_data.pkt_tail       <= cur_tail;
    end
end

out_stable_when_stalled: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    out_valid && !out_ready |=> $stable(out_data)
);

endmodule

`default_nettype wire

//--- logic/rx_meta_pkg.sv
`default_nettype none

package rx_meta_pkg;

localparam int MAX_NB_FLOWS          = 16;
localparam int FLOW_IDX_WIDTH        = 4;
localparam int NB_PKT_QUEUE_MANAGERS = 4;
localparam int PKT_QM_ID_WIDTH       = 2;
localparam int LOCAL_FLOW_WIDTH      = 2;
localparam int NB_LOCAL_FLOWS        = MAX_NB_FLOWS / NB_PKT_QUEUE_MANAGERS;

// Queue registers are 4 KiB apart; the head is the second register of each.
localparam int TABLE_IDX_WIDTH = 5;
localparam int QUEUE_FIELD_LSB = 12;
localparam int MMIO_ADDR_WIDTH = 17;
localparam int REG_SIZE        = 4;
localparam int MMIO_BE_WIDTH   = 16;
localparam int HEAD_REG_INDEX  = 1;

localparam int HEAD_UPD_QUEUE_LEN  = 16;
localparam int HEAD_UPD_SLACK      = 4;
localparam int HEAD_UPD_OCC_WIDTH  = $clog2(HEAD_UPD_QUEUE_LEN + 1);
localparam int IN_QUEUE_LEN        = 8;
localparam int IN_QUEUE_THRESHOLD  = 4;
localparam int IN_QUEUE_OCC_WIDTH  = $clog2(IN_QUEUE_LEN + 1);
localparam int ORDER_QUEUE_LEN     = 8;

localparam int RB_WIDTH       = 12;
localparam int PKT_SIZE_WIDTH = 8;
localparam int CNT_WIDTH      = 32;

typedef logic [FLOW_IDX_WIDTH-1:0]  flow_idx_t;
typedef logic [PKT_QM_ID_WIDTH-1:0] pkt_qm_id_t;
typedef logic [RB_WIDTH-1:0]        rb_ptr_t;
typedef logic [PKT_SIZE_WIDTH-1:0]  pkt_size_t;
typedef logic [CNT_WIDTH-1:0]       counter_t;

typedef struct packed {
    logic [MMIO_ADDR_WIDTH-1:0] address;
    logic [MMIO_BE_WIDTH-1:0]   byteenable;
    logic                       write;
} mmio_write_t;

typedef struct packed {
    flow_idx_t flow_idx;
    pkt_size_t size;
} pkt_meta_t;

typedef struct packed {
    flow_idx_t flow_idx;
    pkt_size_t size;
    logic      descriptor_only;
    logic      needs_dsc;
} rx_meta_t;

typedef struct packed {
    rx_meta_t meta;
    rb_ptr_t  pkt_tail;
} dsc_meta_t;

typedef struct packed {
    rb_ptr_t rb_size;
    logic    desc_per_pkt;
} rx_config_t;

endpackage

`default_nettype wire

//--- logic/rx_meta_top.sv
`timescale 1ns/1ps
`default_nettype none

module rx_meta_top (
    input  logic                     pcie_clk,
    input  logic                     pcie_reset_n,
    input  rx_meta_pkg::rx_config_t  cfg,
    input  rx_meta_pkg::mmio_write_t mmio_write,
    input  logic                     in_meta_valid,
    input  rx_meta_pkg::pkt_meta_t   in_meta,
    output logic                     in_meta_ready,
    output logic                     out_valid,
    output rx_meta_pkg::dsc_meta_t   out_meta,
    input  logic                     out_ready,
    output rx_meta_pkg::counter_t    ignored_head_cnt,
    output rx_meta_pkg::counter_t    head_upd_cnt
);

import rx_meta_pkg::*;

logic                                       head_upd_valid;
flow_idx_t                                  head_upd_flow;
logic                                       head_upd_ready;
logic [NB_PKT_QUEUE_MANAGERS-1:0]           qm_in_valid;
rx_meta_t                                   qm_in_data;
logic [NB_PKT_QUEUE_MANAGERS-1:0]           qm_in_ready;
logic [NB_PKT_QUEUE_MANAGERS-1:0]           qm_out_valid;
dsc_meta_t [NB_PKT_QUEUE_MANAGERS-1:0]      qm_out_data;
logic [NB_PKT_QUEUE_MANAGERS-1:0]           qm_out_ready;
logic                                       order_valid;
pkt_qm_id_t                                 order_id;
logic                                       order_ready;

head_update_monitor head_mon (
    .pcie_clk         (pcie_clk),
    .pcie_reset_n     (pcie_reset_n),
    .mmio_write       (mmio_write),
    .head_upd_valid   (head_upd_valid),
    .head_upd_flow    (head_upd_flow),
    .head_upd_ready   (head_upd_ready),
    .ignored_head_cnt (ignored_head_cnt)
);

meta_dispatcher dispatcher (
    .pcie_clk       (pcie_clk),
    .pcie_reset_n   (pcie_reset_n),
    .head_upd_valid (head_upd_valid),
    .head_upd_flow  (head_upd_flow),
    .head_upd_ready (head_upd_ready),
    .in_meta_valid  (in_meta_valid),
    .in_meta        (in_meta),
    .in_meta_ready  (in_meta_ready),
    .qm_in_valid    (qm_in_valid),
    .qm_in_data     (qm_in_data),
    .qm_in_ready    (qm_in_ready),
    .order_valid    (order_valid),
    .order_id       (order_id),
    .order_ready    (order_ready),
    .head_upd_cnt   (head_upd_cnt)
);

for (genvar i = 0; i < NB_PKT_QUEUE_MANAGERS; i++) begin : g_qm
    pkt_queue_manager qm (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .cfg          (cfg),
        .in_valid     (qm_in_valid[i]),
        .in_data      (qm_in_data),
        .in_ready     (qm_in_ready[i]),
        .out_valid    (qm_out_valid[i]),
        .out_data     (qm_out_data[i]),
        .out_ready    (qm_out_ready[i])
    );
end

ordered_mux out_mux (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .order_valid  (order_valid),
    .order_id     (order_id),
    .order_ready  (order_ready),
    .qm_out_valid (qm_out_valid),
    .qm_out_data  (qm_out_data),
    .qm_out_ready (qm_out_ready),
    .out_valid    (out_valid),
    .out_meta     (out_meta),
    .out_ready    (out_ready)
);

endmodule

`default_nettype wire

//--- logic/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic [WIDTH-1:0]           in_data,
    input  logic                       in_valid,
    output logic                       in_ready,
    output logic [WIDTH-1:0]           out_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [$clog2(DEPTH+1)-1:0] occupancy
);

localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

logic [WIDTH-1:0] mem [DEPTH];
logic [AW-1:0]    wr_ptr;
logic [AW-1:0]    rd_ptr;
logic [CW-1:0]    count;
logic             push;
logic             pop;

assign in_ready  = count != CW'(DEPTH);
assign out_valid = count != '0;
assign out_data  = mem[rd_ptr];
assign occupancy = count;
assign push      = in_valid && in_ready;
assign pop       = out_valid && out_ready;

always_ff @(posedge pcie_clk) begin
    if (push) begin
        mem[wr_ptr] <= in_data;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

// Writers size their thresholds so that a push always finds room.
no_push_when_full: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n) in_valid |-> in_ready
);

endmodule

`default_nettype wire

//--- rx_meta.f
logic/rx_meta_pkg.sv
logic/sync_fifo.sv
logic/head_update_monitor.sv
logic/meta_dispatcher.sv
logic/pkt_queue_manager.sv
logic/ordered_mux.sv
logic/rx_meta_top.sv
test/rx_meta_tb.sv

//--- test/rx_meta_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rx_meta_tb;

import rx_meta_pkg::*;

localparam int SB_DEPTH     = 64;
localparam int WAIT_TIMEOUT = 5000;
localparam logic [MMIO_BE_WIDTH-1:0] HEAD_BE = 16'h00f0;

logic        pcie_clk;
logic        pcie_reset_n;
rx_config_t  cfg;
mmio_write_t mmio_write;
logic        in_meta_valid;
pkt_meta_t   in_meta;
logic        in_meta_ready;
logic        out_valid;
dsc_meta_t   out_meta;
logic        out_ready;
counter_t    ignored_head_cnt;
counter_t    head_upd_cnt;

integer    seed = 32'hc65ebe06;
string     test_name = "reset";
logic      random_ready = 1'b0;

// Per-flow scoreboard. Packets keep their order. Head writes are only counted.
pkt_size_t exp_size [MAX_NB_FLOWS][SB_DEPTH];
int        pkt_wr [MAX_NB_FLOWS];
int        pkt_rd [MAX_NB_FLOWS];
int        pending_heads [MAX_NB_FLOWS];
rb_ptr_t   exp_tail [MAX_NB_FLOWS];
int        desc_seen;
flow_idx_t gen_flow [128];
pkt_size_t gen_size [128];
flow_idx_t cur_flow;
logic      rec_known;
dsc_meta_t exp_rec;

rx_meta_top uut (
    .pcie_clk         (pcie_clk),
    .pcie_reset_n     (pcie_reset_n),
    .cfg              (cfg),
    .mmio_write       (mmio_write),
    .in_meta_valid    (in_meta_valid),
    .in_meta          (in_meta),
    .in_meta_ready    (in_meta_ready),
    .out_valid        (out_valid),
    .out_meta         (out_meta),
    .out_ready        (out_ready),
    .ignored_head_cnt (ignored_head_cnt),
    .head_upd_cnt     (head_upd_cnt)
);

initial begin
    pcie_clk = 1'b0;
    forever #10 pcie_clk = ~pcie_clk;
end

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
endtask

task automatic check_value(input string what, input longint expected, input longint actual);
    value_ok: assert (expected == actual) else begin
        abort_run($sformatf("mismatch in %s: %s expected %0d actual %0d",
            test_name, what, expected, actual));
    end
endtask

// Expected record for whatever flow is on the output right now.
always_comb begin
    cur_flow              = out_meta.meta.flow_idx;
    exp_rec               = '0;
    exp_rec.meta.flow_idx = cur_flow;
    exp_rec.pkt_tail      = exp_tail[cur_flow];
    if (out_meta.meta.descriptor_only) begin
        rec_known                    = pending_heads[cur_flow] > 0;
        exp_rec.meta.descriptor_only = 1'b1;
        exp_rec.meta.needs_dsc       = 1'b1;
    end else begin
        rec_known              = pkt_wr[cur_flow] != pkt_rd[cur_flow];
        exp_rec.meta.size      = exp_size[cur_flow][pkt_rd[cur_flow] % SB_DEPTH];
        // A packet may carry a pending head update of its flow.
        exp_rec.meta.needs_dsc = cfg.desc_per_pkt ||
            (pending_heads[cur_flow] > 0 && out_meta.meta.needs_dsc);
    end
end

always @(posedge pcie_clk) begin
    flow_idx_t f;
    pkt_size_t size;
    logic      merged;
    f      = cur_flow;
    size   = exp_rec.meta.size;
    merged = out_meta.meta.needs_dsc && !cfg.desc_per_pkt;
    if (pcie_reset_n && out_valid && out_ready && rec_known) begin
        if (out_meta.meta.descriptor_only) begin
            pending_heads[f]--;
            desc_seen++;
        end else begin
            if (merged && pending_heads[f] > 0) begin
                pending_heads[f]--;
            end
            exp_tail[f] = rb_ptr_t'((int'(exp_tail[f]) + int'(size)) % int'(cfg.rb_size));
            pkt_rd[f]++;
        end
    end
end

record_expected: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    out_valid && out_ready |-> rec_known
) else abort_run($sformatf("%s: record for flow %0d arrived with nothing outstanding",
    test_name, $sampled(out_meta.meta.flow_idx)));

record_matches: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    out_valid && out_ready && rec_known |-> out_meta == exp_rec
) else abort_run($sformatf("mismatch in %s: record expected %h actual %h",
    test_name, $sampled(exp_rec), $sampled(out_meta)));

out_held: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    out_valid && !out_ready |=> out_valid && $stable(out_meta)
) else abort_run($sformatf("%s: output record changed or dropped while stalled", test_name));

initial begin
    forever begin
        @(posedge pcie_clk);
        #1;
        if (random_ready) begin
            out_ready = ($random(seed) & 3) != 0;
        end
    end
end

function automatic int pending_total();
    int sum;
    sum = 0;
    for (int i = 0; i < MAX_NB_FLOWS; i++) begin
        sum += pending_heads[i] + pkt_wr[i] - pkt_rd[i];
    end
    return sum;
endfunction

task automatic idle(input int cycles);
    repeat (cycles) @(posedge pcie_clk);
    #1;
endtask

task automatic push_expected(input flow_idx_t flow, input pkt_size_t size);
    if (pkt_wr[flow] - pkt_rd[flow] >= SB_DEPTH) begin
        abort_run($sformatf("%s: too many packets outstanding on flow %0d", test_name, flow));
    end
    exp_size[flow][pkt_wr[flow] % SB_DEPTH] = size;
    pkt_wr[flow]++;
endtask

task automatic send_pkt(input flow_idx_t flow, input pkt_size_t size);
    int cycles;
    cycles           = 0;
    in_meta_valid    = 1'b1;
    in_meta.flow_idx = flow;
    in_meta.size     = size;
    @(posedge pcie_clk);
    while (!in_meta_ready) begin
        cycles++;
        if (cycles > WAIT_TIMEOUT) begin
            abort_run($sformatf("%s: packet metadata was never accepted", test_name));
        end
        @(posedge pcie_clk);
    end
    push_expected(flow, size);
    #1;
    in_meta_valid = 1'b0;
endtask

task automatic gen_traffic(input int n, input flow_idx_t flow_mask);
    for (int i = 0; i < n; i++) begin
        gen_flow[i] = flow_idx_t'($random(seed)) & flow_mask;
        gen_size[i] = pkt_size_t'($unsigned($random(seed)) % 255 + 1);
    end
endtask

task automatic send_traffic(input int n);
    for (int i = 0; i < n; i++) begin
        send_pkt(gen_flow[i], gen_size[i]);
    end
endtask

task automatic head_write(input int queue, input logic [MMIO_BE_WIDTH-1:0] be);
    mmio_write.address    = MMIO_ADDR_WIDTH'(queue << QUEUE_FIELD_LSB) +
        MMIO_ADDR_WIDTH'(HEAD_REG_INDEX * REG_SIZE);
    mmio_write.byteenable = be;
    mmio_write.write      = 1'b1;
    if (queue < MAX_NB_FLOWS && be[HEAD_REG_INDEX*REG_SIZE +: REG_SIZE] == '1) begin
        pending_heads[queue]++;
    end
    @(posedge pcie_clk);
    #1;
    mmio_write.write = 1'b0;
endtask

task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (pending_total() != 0) begin
        @(posedge pcie_clk);
        #1;
        cycles++;
        if (cycles > WAIT_TIMEOUT) begin
            abort_run($sformatf("%s: timeout, %0d records never came out",
                test_name, pending_total()));
        end
    end
endtask

task automatic wait_desc_records(input int target);
    int cycles;
    cycles = 0;
    while (desc_seen < target) begin
        @(posedge pcie_clk);
        #1;
        cycles++;
        if (cycles > WAIT_TIMEOUT) begin
            abort_run($sformatf("%s: timeout waiting for descriptor records", test_name));
        end
    end
endtask

initial begin
    counter_t upd_start;
    counter_t ign_start;
    int       desc_start;
    int       ignored;
    for (int i = 0; i < MAX_NB_FLOWS; i++) begin
        pkt_wr[i]        = 0;
        pkt_rd[i]        = 0;
        pending_heads[i] = 0;
        exp_tail[i]      = '0;
    end
    desc_seen          = 0;
    pcie_reset_n       = 1'b0;
    cfg.rb_size        = 12'd300;
    cfg.desc_per_pkt   = 1'b0;
    mmio_write         = '0;
    in_meta_valid      = 1'b0;
    in_meta            = '0;
    out_ready          = 1'b1;
    idle(10);
    pcie_reset_n = 1'b1;
    check_value("out_valid", 0, out_valid);
    check_value("ignored_head_cnt", 0, ignored_head_cnt);
    check_value("head_upd_cnt", 0, head_upd_cnt);

    test_name = "packets";
    gen_traffic(60, 4'hf);
    send_traffic(60);
    wait_drained();

    test_name        = "desc_per_pkt";
    cfg.desc_per_pkt = 1'b1;
    gen_traffic(40, 4'hf);
    send_traffic(40);
    wait_drained();
    cfg.desc_per_pkt = 1'b0;

    // Partial byte enables and out-of-range queues come first.
    test_name = "head_writes";
    upd_start = head_upd_cnt;
    head_write(3, 16'h0070);
    head_write(5, 16'h00e0);
    head_write(16, HEAD_BE);
    head_write(31, 16'hffff);
    idle(20);
    check_value("head_upd_cnt", upd_start, head_upd_cnt);
    for (int i = 0; i < MAX_NB_FLOWS; i++) begin
        head_write(i, (i % 2) ? 16'hffff : HEAD_BE);
        idle(2);
    end
    wait_drained();
    check_value("head_upd_cnt", upd_start + 16, head_upd_cnt);

    test_name = "mixed";
    upd_start = head_upd_cnt;
    gen_traffic(40, 4'h3);
    fork
        send_traffic(40);
        for (int i = 0; i < 12; i++) begin
            head_write(i % 4, HEAD_BE);
            idle(2);
        end
    join
    wait_drained();
    check_value("head_upd_cnt", upd_start + 12, head_upd_cnt);

    test_name  = "stalled_heads";
    out_ready  = 1'b0;
    upd_start  = head_upd_cnt;
    ign_start  = ignored_head_cnt;
    desc_start = desc_seen;
    for (int i = 0; i < 30; i++) begin
        head_write(i % MAX_NB_FLOWS, HEAD_BE);
    end
    ignored = int'(ignored_head_cnt - ign_start);
    some_ignored: assert (ignored != 0) else begin
        abort_run("no head write was ignored while the output was stalled");
    end
    out_ready = 1'b1;
    wait_desc_records(desc_start + 30 - ignored);
    // Any surplus descriptor record shows up within this window.
    idle(20);
    check_value("accepted head updates", 30 - ignored, head_upd_cnt - upd_start);
    check_value("records plus ignored", 30, desc_seen - desc_start + ignored);
    check_value("heads without record", ignored, pending_total());
    for (int i = 0; i < MAX_NB_FLOWS; i++) begin
        pending_heads[i] = 0;
    end

    test_name = "random_ready";
    gen_traffic(80, 4'hf);
    random_ready = 1'b1;
    send_traffic(80);
    wait_drained();
    random_ready = 1'b0;
    out_ready    = 1'b1;
    idle(5);

    $display("Simulation completed successfully");
    $finish;
end

endmodule

`default_nettype wire
